//--- sim/program_stimulus.mem
// First word is the instruction count. Each instruction line holds the word (bit 31 set
// means issue back-to-back) and its expected commit value. Last come final r0 to r15
0000001e
41000007 00000007 // ADDI r1, r0, 7
42000003 00000003 // ADDI r2, r0, 3
03120000 0000000a // ADD  r3, r1, r2
14310000 00000003 // SUB  r4, r3, r1
55340000 0000001e // MUL  r5, r3, r4
07510000 00000025 // ADD  r7, r5, r1
58550000 00000384 // MUL  r8, r5, r5
4900fffe fffffffe // ADDI r9, r0, -2
3a120000 00000004 // XOR  r10, r1, r2
2b910000 00000006 // AND  r11, r9, r1
0c890000 00000382 // ADD  r12, r8, r9
40100064 0000006b // ADDI r0, r1, 100
0d010000 00000007 // ADD  r13, r0, r1
46000001 00000001 // ADDI r6, r0, 1
d6620000 00000003 // MUL  r6, r6, r2 back-to-back chain
d6620000 00000009
d6620000 0000001b
d6620000 00000051
d6620000 000000f3
d6620000 000002d9
d6620000 0000088b
d6620000 000019a1
d6620000 00004ce3
d6620000 0000e6a9
5e660000 cfd41b91 // MUL  r14, r6, r6
01110000 0000000e // ADD  r1, r1, r1
41110100 0000010e // ADDI r1, r1, 256
1f0e0000 302be46f // SUB  r15, r0, r14
53f90000 9fa83722 // MUL  r3, r15, r9
34380000 9fa834a6 // XOR  r4, r3, r8
00000000 0000010e 00000003 9fa83722
9fa834a6 0000001e 0000e6a9 00000025
00000384 fffffffe 00000004 00000006
00000382 00000007 cfd41b91 302be46f

//--- tb.f
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/instr_dispatch.sv
verilog/register_file.sv
verilog/reorder_buffer.sv
verilog/alu_combo.sv
verilog/mult_combo.sv
verilog/cdb_arbiter.sv
verilog/cpu_core.sv
sim/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cpu_core -f tb.f -o sim_cpu_core

./obj_dir/sim_cpu_core > sim.log 2>&1 || true
cat sim.log

if grep -q "^=== PASS ===$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- sim/tb_cpu_core.sv
`timescale 1ns/100ps

module tb_cpu_core
  import isa_pkg::*;
  import core_pkg::*;
();

  localparam int XLEN         = 32;
  localparam int STIM_WORDS   = 256;
  localparam int MAX_INSTRS   = 100;
  localparam int ACCEPT_LIMIT = 200;
  localparam int COMMIT_LIMIT = 500;

  logic            clk;
  logic            reset;
  logic            issue_valid;
  instr_t          issue_instr;
  logic            stall;
  commit_t         commit;
  reg_idx_t        debug_reg;
  logic [XLEN-1:0] debug_value;

  logic [31:0] stim[STIM_WORDS];
  int          num_instrs;
  int          commits_seen;
  int          checks;
  int          errors;
  int          stall_cycles;
  logic        aborted;
  logic [31:0] lfsr_state;

  cpu_core #(
    .XLEN(XLEN), .ROB_DEPTH(8), .RS_DEPTH(4)
  ) dut (
    .clk(clk), .reset(reset),
    .issue_valid(issue_valid), .issue_instr(issue_instr), .stall(stall),
    .commit(commit), .debug_reg(debug_reg), .debug_value(debug_value)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_idle(output int n);
    n = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      n = (n << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t %s actual=%h expected=%h", $time, name, actual, expected);
    end
  endtask

  task automatic report_problem(string what);
    errors++;
    $display("ERROR %0t %s", $time, what);
  endtask

  task automatic drive_program();
    logic [31:0] word;
    int          idle;
    int          waited;
    logic        accepted;
    for (int i = 0; i < num_instrs && !aborted; i++) begin
      word = stim[1 + 2 * i];
      idle = 0;
      // Bit 31 asks for a back-to-back issue
      if (!word[31]) draw_idle(idle);
      if (idle > 0) begin
        issue_valid <= 1'b0;
        repeat (idle) @(posedge clk);
      end
      issue_valid <= 1'b1;
      issue_instr <= instr_t'(word[30:0]);
      accepted = 1'b0;
      waited   = 0;
      while (!accepted && !aborted) begin
        @(posedge clk);
        if (!stall) begin
          accepted = 1'b1;
        end else begin
          stall_cycles++;
          waited++;
          if (waited > ACCEPT_LIMIT) begin
            report_problem($sformatf("instruction %0d was never accepted", i));
            aborted = 1'b1;
          end
        end
      end
    end
    issue_valid <= 1'b0;
  endtask

  task automatic read_registers();
    for (int r = 0; r < 16; r++) begin
      @(posedge clk);
      debug_reg <= reg_idx_t'(r);
      @(posedge clk);
      check_value($sformatf("debug_value[r%0d]", r), debug_value,
                  stim[1 + 2 * num_instrs + r]);
    end
  endtask

  // Commits must come in program order
  always @(posedge clk) begin
    if (!reset && commit.valid) begin
      if (commits_seen >= num_instrs) begin
        report_problem("a commit arrived after the last instruction had retired");
      end else begin
        check_value($sformatf("commit[%0d].dest", commits_seen), 32'(commit.dest),
                    32'(stim[1 + 2 * commits_seen][27:24]));
        check_value($sformatf("commit[%0d].value", commits_seen), commit.value,
                    stim[2 + 2 * commits_seen]);
      end
      commits_seen++;
    end
  end

  initial begin
    int last_seen;
    int quiet;
    reset        = 1'b1;
    issue_valid  = 1'b0;
    issue_instr  = '0;
    debug_reg    = '0;
    commits_seen = 0;
    checks       = 0;
    errors       = 0;
    stall_cycles = 0;
    aborted      = 1'b0;
    lfsr_state   = 32'h736f;
    num_instrs   = 0;
    $readmemh("sim/program_stimulus.mem", stim);
    num_instrs = int'(stim[0]);
    if (num_instrs < 1 || num_instrs > MAX_INSTRS) begin
      report_problem("stimulus file is missing or its instruction count is out of range");
      aborted = 1'b1;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    if (!aborted) begin
      fork
        drive_program();
      join_none
    end
    last_seen = 0;
    quiet     = 0;
    while (commits_seen < num_instrs && !aborted) begin
      @(posedge clk);
      if (commits_seen != last_seen) begin
        last_seen = commits_seen;
        quiet     = 0;
      end else begin
        quiet++;
        if (quiet > COMMIT_LIMIT) begin
          report_problem($sformatf("commits stopped after %0d of %0d instructions",
                                   commits_seen, num_instrs));
          aborted = 1'b1;
        end
      end
    end
    if (!aborted) begin
      read_registers();
      // The multiply burst has to back up into the core
      check_value("stall_seen", 32'(stall_cycles > 0), 32'd1);
    end
    $display("checks=%0d errors=%0d commits=%0d/%0d stall_cycles=%0d",
             checks, errors, commits_seen, num_instrs, stall_cycles);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- verilog/cpu_core.sv
`timescale 1ns/100ps

module cpu_core
  import isa_pkg::*;
  import core_pkg::*;
#(
  parameter int XLEN      = 32,
  parameter int ROB_DEPTH = 8,
  parameter int RS_DEPTH  = 4
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            issue_valid,
  input  instr_t          issue_instr,
  output logic            stall,
  output commit_t         commit,
  input  reg_idx_t        debug_reg,
  output logic [XLEN-1:0] debug_value
);

  localparam int MULT_ADDRESS = 1;
  localparam int ALU_ADDRESS  = 2;

  reg_idx_t [1:0]         rf_src;
  logic [1:0][XLEN-1:0]   rf_value;
  rob_tag_t [1:0]         rf_tag;
  logic [1:0]             rf_renamed;
  logic                   rob_alloc, rob_full, rename_valid;
  reg_idx_t               alloc_dest;
  rob_tag_t               alloc_tag, commit_tag;
  rob_tag_t [1:0]         query_tag;
  logic [1:0]             query_done;
  logic [1:0][XLEN-1:0]   query_value;
  cdb_t                   cdb, alu_result, mult_result;
  rs_entry_t              rs_entry;
  logic                   alu_load, mult_load, alu_full, mult_full;
  logic                   alu_req, mult_req, alu_grant, mult_grant;

  instr_dispatch instr_dispatch (
    .clk(clk), .reset(reset),
    .issue_valid(issue_valid), .issue_instr(issue_instr), .stall(stall),
    .rf_src(rf_src), .rf_value(rf_value), .rf_tag(rf_tag), .rf_renamed(rf_renamed),
    .rob_alloc(rob_alloc), .alloc_dest(alloc_dest), .rob_alloc_tag(alloc_tag),
    .rob_full(rob_full), .rename_valid(rename_valid),
    .rob_query_tag(query_tag), .rob_query_done(query_done), .rob_query_value(query_value),
    .cdb(cdb), .alu_load(alu_load), .mult_load(mult_load), .rs_entry(rs_entry),
    .alu_full(alu_full), .mult_full(mult_full)
  );

  register_file register_file (
    .clk(clk), .reset(reset),
    .rd_idx(rf_src), .rd_value(rf_value), .rd_tag(rf_tag), .rd_renamed(rf_renamed),
    .rename_valid(rename_valid), .rename_reg(alloc_dest), .rename_tag(alloc_tag),
    .commit(commit), .commit_tag(commit_tag),
    .debug_reg(debug_reg), .debug_value(debug_value)
  );

  reorder_buffer #(
    .XLEN(XLEN), .ROB_DEPTH(ROB_DEPTH)
  ) reorder_buffer (
    .clk(clk), .reset(reset),
    .alloc(rob_alloc), .alloc_dest(alloc_dest), .alloc_tag(alloc_tag), .full(rob_full),
    .query_tag(query_tag), .query_done(query_done), .query_value(query_value),
    .cdb(cdb), .commit(commit), .commit_tag(commit_tag)
  );

  alu_combo #(
    .XLEN(XLEN), .RS_DEPTH(RS_DEPTH), .ARBITER_ADDRESS(ALU_ADDRESS)
  ) alu_combo (
    .clk(clk), .reset(reset), .load(alu_load), .entry(rs_entry), .cdb(cdb),
    .full(alu_full), .cdb_req(alu_req), .result(alu_result), .cdb_grant(alu_grant)
  );

  mult_combo #(
    .XLEN(XLEN), .RS_DEPTH(RS_DEPTH), .ARBITER_ADDRESS(MULT_ADDRESS)
  ) mult_combo (
    .clk(clk), .reset(reset), .load(mult_load), .entry(rs_entry), .cdb(cdb),
    .full(mult_full), .cdb_req(mult_req), .result(mult_result), .cdb_grant(mult_grant)
  );

  cdb_arbiter #(
    .XLEN(XLEN), .ALU_ADDRESS(ALU_ADDRESS), .MULT_ADDRESS(MULT_ADDRESS)
  ) cdb_arbiter (
    .clk(clk), .reset(reset),
    .alu_req(alu_req), .mult_req(mult_req),
    .alu_result(alu_result), .mult_result(mult_result),
    .alu_grant(alu_grant), .mult_grant(mult_grant), .cdb(cdb)
  );

endmodule

//--- verilog/cdb_arbiter.sv
`timescale 1ns/100ps

module cdb_arbiter
  import core_pkg::*;
#(
  parameter int XLEN         = 32,
  parameter int ALU_ADDRESS  = 2,
  parameter int MULT_ADDRESS = 1
) (
  input  logic clk,
  input  logic reset,
  input  logic alu_req,
  input  logic mult_req,
  input  cdb_t alu_result,
  input  cdb_t mult_result,
  output logic alu_grant,
  output logic mult_grant,
  output cdb_t cdb
);

  // Lower address has priority
  localparam bit ALU_WINS = ALU_ADDRESS < MULT_ADDRESS;

  assign alu_grant  = alu_req && (!mult_req || ALU_WINS);
  assign mult_grant = mult_req && (!alu_req || !ALU_WINS);
  assign cdb = alu_grant ? alu_result : (mult_grant ? mult_result : '0);

  initial assert (XLEN == CDB_XLEN) else $fatal(1, "XLEN must match the CDB value width");

  a_grant_to_req: assert property (@(posedge clk) disable iff (reset)
    (alu_grant -> alu_req) && (mult_grant -> mult_req));
  a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0({alu_grant, mult_grant}));
  // A loser must keep its request and result until served
  a_alu_hold: assert property (@(posedge clk) disable iff (reset)
    alu_req && !alu_grant |=> alu_req && $stable(alu_result));
  a_mult_hold: assert property (@(posedge clk) disable iff (reset)
    mult_req && !mult_grant |=> mult_req && $stable(mult_result));

endmodule

//--- verilog/mult_combo.sv
`timescale 1ns/100ps

module mult_combo
  import core_pkg::*;
#(
  parameter int XLEN            = 32,
  parameter int RS_DEPTH        = 4,
  parameter int ARBITER_ADDRESS = 1
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      load,
  input  rs_entry_t entry,
  input  cdb_t      cdb,
  output logic      full,
  output logic      cdb_req,
  output cdb_t      result,
  input  logic      cdb_grant
);

  localparam int IDX_W = $clog2(RS_DEPTH);
  localparam int HALF  = XLEN / 2;
  typedef logic [IDX_W-1:0] idx_t;

  rs_entry_t           stations[RS_DEPTH];
  rs_entry_t           stations_n[RS_DEPTH];
  logic [RS_DEPTH-1:0] ready;
  idx_t                pick;
  logic                issue;
  logic                adv1, adv2, adv3;
  logic                s1_valid, s2_valid;
  rob_tag_t            s1_tag, s2_tag;
  logic [XLEN-1:0]     s1_a, s1_b, s2_lo;
  logic [HALF-1:0]     s2_hi;
  cdb_t                s3;

  always_comb begin
    pick = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      ready[i] = rs_ready(stations[i]);
      if (ready[i]) pick = idx_t'(i);
    end
  end

  // Bubbles collapse and only a held last stage freezes everything
  assign adv3  = !s3.valid || cdb_grant;
  assign adv2  = !s2_valid || adv3;
  assign adv1  = !s1_valid || adv2;
  assign issue = adv1 && |ready;
  assign full  = stations[RS_DEPTH-1].busy;

  always_comb begin
    logic placed;
    placed = 1'b0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      stations_n[i] = rs_wakeup(stations[i], cdb);
    end
    if (issue) begin
      for (int i = 0; i < RS_DEPTH - 1; i++) begin
        if (i >= pick) stations_n[i] = stations_n[i+1];
      end
      stations_n[RS_DEPTH-1].busy = 1'b0;
    end
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (load && !placed && !stations_n[i].busy) begin
        stations_n[i] = entry;
        placed        = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      stations[i] <= stations_n[i];
      if (reset) stations[i].busy <= 1'b0;
    end
  end

  // Low half of a*b is a_lo*b plus a_hi*b_lo shifted up while a_hi*b_hi drops out
  always_ff @(posedge clk) begin
    if (adv1) begin
      s1_valid <= issue;
      s1_tag   <= stations[pick].dest_tag;
      s1_a     <= stations[pick].op1;
      s1_b     <= stations[pick].op2;
    end
    if (adv2) begin
      s2_valid <= s1_valid;
      s2_tag   <= s1_tag;
      s2_lo    <= s1_a[HALF-1:0] * s1_b;
      s2_hi    <= s1_a[XLEN-1:HALF] * s1_b[HALF-1:0];
    end
    if (adv3) begin
      s3.valid <= s2_valid;
      s3.tag   <= s2_tag;
      s3.value <= s2_lo + {s2_hi, {HALF{1'b0}}};
    end
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3.valid <= 1'b0;
    end
  end

  assign cdb_req = s3.valid;
  assign result  = s3;

  initial assert (ARBITER_ADDRESS > 0) else $fatal(1, "MUL arbiter address must be nonzero");

endmodule

//--- verilog/alu_combo.sv
`timescale 1ns/100ps

module alu_combo
  import isa_pkg::*;
  import core_pkg::*;
#(
  parameter int XLEN            = 32,
  parameter int RS_DEPTH        = 4,
  parameter int ARBITER_ADDRESS = 2
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      load,
  input  rs_entry_t entry,
  input  cdb_t      cdb,
  output logic      full,
  output logic      cdb_req,
  output cdb_t      result,
  input  logic      cdb_grant
);

  localparam int IDX_W = $clog2(RS_DEPTH);
  typedef logic [IDX_W-1:0] idx_t;

  rs_entry_t         stations[RS_DEPTH];
  rs_entry_t         stations_n[RS_DEPTH];
  rs_entry_t         src;
  cdb_t              out_q;
  logic [RS_DEPTH-1:0] ready;
  idx_t              pick;
  logic              out_free;
  logic              issue_rs;
  logic              take_new;

  function automatic logic [XLEN-1:0] alu_exec(rs_entry_t e);
    case (e.opcode)
      SUB:     return e.op1 - e.op2;
      AND:     return e.op1 & e.op2;
      XOR:     return e.op1 ^ e.op2;
      default: return e.op1 + e.op2;
    endcase
  endfunction

  // Stations stay packed toward index 0 so the lowest ready index is the oldest
  always_comb begin
    pick = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      ready[i] = rs_ready(stations[i]);
      if (ready[i]) pick = idx_t'(i);
    end
  end

  assign out_free = !out_q.valid || cdb_grant;
  assign issue_rs = out_free && |ready;
  // A ready instruction with nothing older waiting goes straight to the output
  assign take_new = load && rs_ready(entry) && !(|ready) && out_free;
  assign src      = issue_rs ? stations[pick] : entry;
  assign full     = stations[RS_DEPTH-1].busy;

  always_comb begin
    logic placed;
    placed = 1'b0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      stations_n[i] = rs_wakeup(stations[i], cdb);
    end
    if (issue_rs) begin
      for (int i = 0; i < RS_DEPTH - 1; i++) begin
        if (i >= pick) stations_n[i] = stations_n[i+1];
      end
      stations_n[RS_DEPTH-1].busy = 1'b0;
    end
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (load && !take_new && !placed && !stations_n[i].busy) begin
        stations_n[i] = entry;
        placed        = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      stations[i] <= stations_n[i];
      if (reset) stations[i].busy <= 1'b0;
    end
  end

  // Result held here until the arbiter grants the bus
  always_ff @(posedge clk) begin
    if (out_free) begin
      out_q.valid <= issue_rs || take_new;
      out_q.tag   <= src.dest_tag;
      out_q.value <= alu_exec(src);
    end
    if (reset) out_q.valid <= 1'b0;
  end

  assign cdb_req = out_q.valid;
  assign result  = out_q;

  initial assert (ARBITER_ADDRESS > 0) else $fatal(1, "ALU arbiter address must be nonzero");

endmodule

//--- verilog/reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer
  import isa_pkg::*;
  import core_pkg::*;
#(
  parameter int XLEN      = 32,
  parameter int ROB_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 alloc,
  input  reg_idx_t             alloc_dest,
  output rob_tag_t             alloc_tag,
  output logic                 full,
  input  rob_tag_t [1:0]       query_tag,
  output logic [1:0]           query_done,
  output logic [1:0][XLEN-1:0] query_value,
  input  cdb_t                 cdb,
  output commit_t              commit,
  output rob_tag_t             commit_tag
);

  rob_state_e                     state[ROB_DEPTH];
  reg_idx_t                       dest[ROB_DEPTH];
  logic [XLEN-1:0]                value[ROB_DEPTH];
  rob_tag_t                       head;
  rob_tag_t                       tail;
  logic [$clog2(ROB_DEPTH+1)-1:0] count;
  logic                           retire;

  function automatic rob_tag_t bump(rob_tag_t p);
    return (p == rob_tag_t'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign retire    = state[head] == DONE;
  assign full      = count == ROB_DEPTH;
  assign alloc_tag = tail;

  always_ff @(posedge clk) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        state[i] <= FREE;
      end
    end else begin
      if (cdb.valid) begin
        state[cdb.tag] <= DONE;
      end
      if (retire) begin
        state[head] <= FREE;
        head        <= bump(head);
      end
      if (alloc) begin
        state[tail] <= PENDING;
        tail        <= bump(tail);
      end
      case ({alloc, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cdb.valid) begin
      value[cdb.tag] <= cdb.value;
    end
    if (alloc) begin
      dest[tail] <= alloc_dest;
    end
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      query_done[i]  = state[query_tag[i]] == DONE;
      query_value[i] = value[query_tag[i]];
    end
  end

  // Head retires in the same cycle it is seen DONE
  assign commit.valid = retire;
  assign commit.dest  = dest[head];
  assign commit.value = value[head];
  assign commit_tag   = head;

  a_alloc_not_full: assert property (@(posedge clk) disable iff (reset)
    alloc |-> !full);
  a_cdb_live_entry: assert property (@(posedge clk) disable iff (reset)
    cdb.valid |-> state[cdb.tag] != FREE);

endmodule

//--- verilog/register_file.sv
`timescale 1ns/100ps

module register_file
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  reg_idx_t [1:0]           rd_idx,
  output logic [1:0][CDB_XLEN-1:0] rd_value,
  output rob_tag_t [1:0]           rd_tag,
  output logic [1:0]               rd_renamed,
  input  logic                     rename_valid,
  input  reg_idx_t                 rename_reg,
  input  rob_tag_t                 rename_tag,
  input  commit_t                  commit,
  input  rob_tag_t                 commit_tag,
  input  reg_idx_t                 debug_reg,
  output logic [CDB_XLEN-1:0]      debug_value
);

  logic [CDB_XLEN-1:0] values[16];
  rob_tag_t            tags[16];
  logic [15:0]         renamed;

  always_ff @(posedge clk) begin
    if (reset) begin
      renamed <= '0;
      for (int i = 0; i < 16; i++) begin
        values[i] <= '0;
      end
    end else begin
      if (commit.valid && commit.dest != '0) begin
        values[commit.dest] <= commit.value;
        // Only drop the tag if no younger instruction renamed the register
        if (tags[commit.dest] == commit_tag) begin
          renamed[commit.dest] <= 1'b0;
        end
      end
      if (rename_valid) begin
        renamed[rename_reg] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rename_valid) begin
      tags[rename_reg] <= rename_tag;
    end
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rd_value[i]   = values[rd_idx[i]];
      rd_tag[i]     = tags[rd_idx[i]];
      rd_renamed[i] = renamed[rd_idx[i]];
    end
  end

  assign debug_value = values[debug_reg];

  a_no_r0_rename: assert property (@(posedge clk) disable iff (reset)
    rename_valid |-> rename_reg != '0);

endmodule

//--- verilog/instr_dispatch.sv
`timescale 1ns/100ps

module instr_dispatch
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     issue_valid,
  input  instr_t                   issue_instr,
  output logic                     stall,
  output reg_idx_t [1:0]           rf_src,
  input  logic [1:0][CDB_XLEN-1:0] rf_value,
  input  rob_tag_t [1:0]           rf_tag,
  input  logic [1:0]               rf_renamed,
  output logic                     rob_alloc,
  output reg_idx_t                 alloc_dest,
  input  rob_tag_t                 rob_alloc_tag,
  input  logic                     rob_full,
  output logic                     rename_valid,
  output rob_tag_t [1:0]           rob_query_tag,
  input  logic [1:0]               rob_query_done,
  input  logic [1:0][CDB_XLEN-1:0] rob_query_value,
  input  cdb_t                     cdb,
  output logic                     alu_load,
  output logic                     mult_load,
  output rs_entry_t                rs_entry,
  input  logic                     alu_full,
  input  logic                     mult_full
);

  logic                     use_mult;
  logic                     accept;
  logic [1:0][CDB_XLEN-1:0] op_value;
  logic [1:0]               op_ready;

  assign use_mult = issue_instr.opcode == MUL;
  assign stall    = issue_valid && (rob_full || (use_mult ? mult_full : alu_full));
  assign accept   = issue_valid && !stall;

  assign rf_src        = {issue_instr.src2, issue_instr.src1};
  assign rob_query_tag = rf_tag;
  assign rob_alloc     = accept;
  assign alloc_dest    = issue_instr.dest;
  // r0 keeps no rename tag but its result still retires through the ROB
  assign rename_valid  = accept && issue_instr.dest != '0;

  // Operand comes from the register file, a finished ROB entry or this cycle's broadcast
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      op_value[i] = rf_value[i];
      op_ready[i] = 1'b1;
      if (rf_renamed[i]) begin
        if (rob_query_done[i]) begin
          op_value[i] = rob_query_value[i];
        end else if (cdb.valid && cdb.tag == rf_tag[i]) begin
          op_value[i] = cdb.value;
        end else begin
          op_ready[i] = 1'b0;
        end
      end
    end
  end

  always_comb begin
    rs_entry.busy      = 1'b1;
    rs_entry.opcode    = issue_instr.opcode;
    rs_entry.dest_tag  = rob_alloc_tag;
    rs_entry.op1       = op_value[0];
    rs_entry.op1_ready = op_ready[0];
    rs_entry.op1_tag   = rf_tag[0];
    rs_entry.op2       = op_value[1];
    rs_entry.op2_ready = op_ready[1];
    rs_entry.op2_tag   = rf_tag[1];
    if (issue_instr.opcode == ADDI) begin
      rs_entry.op2       = {{(CDB_XLEN - 16){issue_instr.imm[15]}}, issue_instr.imm};
      rs_entry.op2_ready = 1'b1;
    end
  end

  assign alu_load  = accept && !use_mult;
  assign mult_load = accept && use_mult;

  a_one_unit: assert property (@(posedge clk) disable iff (reset)
    accept |-> $onehot({alu_load, mult_load}));

endmodule

//--- verilog/core_pkg.sv
package core_pkg;

  import isa_pkg::*;

  // Width of every value carried on the CDB
  localparam int CDB_XLEN = 32;

  typedef logic [2:0] rob_tag_t;

  typedef struct packed {
    logic                valid;
    rob_tag_t            tag;
    logic [CDB_XLEN-1:0] value;
  } cdb_t;

  typedef struct packed {
    logic                busy;
    opcode_e             opcode;
    rob_tag_t            dest_tag;
    logic [CDB_XLEN-1:0] op1;
    logic [CDB_XLEN-1:0] op2;
    logic                op1_ready;
    logic                op2_ready;
    rob_tag_t            op1_tag;
    rob_tag_t            op2_tag;
  } rs_entry_t;

  typedef struct packed {
    logic                valid;
    reg_idx_t            dest;
    logic [CDB_XLEN-1:0] value;
  } commit_t;

  typedef enum logic [1:0] {
    FREE    = 2'd0,
    PENDING = 2'd1,
    DONE    = 2'd2
  } rob_state_e;

  function automatic logic rs_ready(rs_entry_t e);
    return e.busy && e.op1_ready && e.op2_ready;
  endfunction

  // Operand capture from a CDB broadcast
  function automatic rs_entry_t rs_wakeup(rs_entry_t e, cdb_t c);
    rs_entry_t r;
    r = e;
    if (c.valid && e.busy && !e.op1_ready && e.op1_tag == c.tag) begin
      r.op1       = c.value;
      r.op1_ready = 1'b1;
    end
    if (c.valid && e.busy && !e.op2_ready && e.op2_tag == c.tag) begin
      r.op2       = c.value;
      r.op2_ready = 1'b1;
    end
    return r;
  endfunction

endpackage

//--- verilog/isa_pkg.sv
package isa_pkg;

  typedef enum logic [2:0] {
    ADD  = 3'd0,
    SUB  = 3'd1,
    AND  = 3'd2,
    XOR  = 3'd3,
    ADDI = 3'd4,
    MUL  = 3'd5
  } opcode_e;

  // Register 0 always reads zero
  typedef logic [3:0] reg_idx_t;

  // imm is sign-extended and used by ADDI only
  typedef struct packed {
    opcode_e     opcode;
    reg_idx_t    dest;
    reg_idx_t    src1;
    reg_idx_t    src2;
    logic [15:0] imm;
  } instr_t;

endpackage
